/* hw/sdhc_config.svh */
// build-time sizes and register map of the SD host transmit path
// SDHC_CLK_HALF_DIV must be 2 or more, SDHC_BLOCK_WORDS a power of two of 2 or more
`ifndef SDHC_CONFIG_SVH
`define SDHC_CONFIG_SVH

// clk_i cycles per half period of the SD clock
`define SDHC_CLK_HALF_DIV 2

// 32-bit words per data block, 4 words give a 16 byte block
`define SDHC_BLOCK_WORDS 4

// host register map
`define SDHC_ADDR_ARG  2'd0
`define SDHC_ADDR_CMD  2'd1
`define SDHC_ADDR_DATA 2'd2
`define SDHC_ADDR_XFER 2'd3

`endif

/* hw/sdhc_pkg.sv */
// shared types of the SD host transmit path
package sdhc_pkg;

  typedef logic [1:0]  reg_addr_t;
  typedef logic [31:0] word_t;
  typedef logic [5:0]  cmd_index_t;
  typedef logic [6:0]  crc7_t;
  typedef logic [15:0] crc16_t;
  typedef logic [3:0]  nibble_t;    // one bit per DAT lane

  typedef struct packed {
    logic      wr;
    reg_addr_t addr;
    word_t     wdata;
  } host_req_t;

  typedef struct packed {
    logic cmd_busy;
    logic dat_busy;
    logic cmd_done;   // 1-cycle pulse
    logic dat_done;   // 1-cycle pulse
  } host_status_t;

  typedef struct packed {
    cmd_index_t index;
    word_t      argument;
  } cmd_frame_t;

  typedef struct packed {
    logic fall;
    logic rise;
  } sd_clk_en_t;

  typedef struct packed {
    logic    valid;
    nibble_t data;
    logic    crc_shift;
  } lane_in_t;

  typedef enum logic [1:0] {cmd_idle, cmd_send, cmd_crc, cmd_stop} cmd_state_t;

  typedef enum logic [2:0] {dat_idle, dat_start, dat_data, dat_crc, dat_stop} dat_state_t;

endpackage

/* hw/sdhc_regs.sv */
// host register decode for single-cycle write strobes without back-pressure
// writes that hit a busy path or a full buffer are dropped silently
`timescale 1ns/1ps
`include "sdhc_config.svh"

module sdhc_regs (
  input  logic                   clk_i,
  input  logic                   software_reset_cmd_q,
  input  sdhc_pkg::host_req_t    host_req_i,
  input  logic                   cmd_done_i,
  input  logic                   dat_done_i,
  input  logic                   buf_full_i,
  output sdhc_pkg::host_status_t host_status_o,
  output sdhc_pkg::cmd_frame_t   cmd_frame_o,
  output logic                   cmd_start_o,
  output logic                   data_push_o,
  output logic                   xfer_start_o,
  output sdhc_pkg::word_t        push_word_o
);

  sdhc_pkg::word_t arg_q;
  logic            cmd_busy_q, dat_busy_q;
  logic            cmd_done_q, dat_done_q;
  logic            wr_arg, wr_cmd, wr_data, wr_xfer;

  assign wr_arg  = host_req_i.wr && (host_req_i.addr == `SDHC_ADDR_ARG);
  assign wr_cmd  = host_req_i.wr && (host_req_i.addr == `SDHC_ADDR_CMD);
  assign wr_data = host_req_i.wr && (host_req_i.addr == `SDHC_ADDR_DATA);
  assign wr_xfer = host_req_i.wr && (host_req_i.addr == `SDHC_ADDR_XFER);

  assign cmd_start_o  = wr_cmd && !cmd_busy_q;
  assign xfer_start_o = wr_xfer && !dat_busy_q;
  assign data_push_o  = wr_data && !dat_busy_q && !buf_full_i;
  assign push_word_o  = host_req_i.wdata;

  // index comes straight from the write and sd_cmd_tx latches the frame on start
  assign cmd_frame_o.index    = host_req_i.wdata[5:0];
  assign cmd_frame_o.argument = arg_q;

  always_ff @(posedge clk_i) begin
    if (wr_arg)
      arg_q <= host_req_i.wdata;
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      cmd_busy_q <= 1'b0;
      dat_busy_q <= 1'b0;
      cmd_done_q <= 1'b0;
      dat_done_q <= 1'b0;
    end else begin
      cmd_done_q <= cmd_done_i;   // busy drops in the same cycle as the pulse
      dat_done_q <= dat_done_i;
      if (cmd_start_o)
        cmd_busy_q <= 1'b1;
      else if (cmd_done_i)
        cmd_busy_q <= 1'b0;
      if (xfer_start_o)
        dat_busy_q <= 1'b1;
      else if (dat_done_i)
        dat_busy_q <= 1'b0;
    end
  end

  assign host_status_o = '{cmd_busy: cmd_busy_q, dat_busy: dat_busy_q,
                           cmd_done: cmd_done_q, dat_done: dat_done_q};

  // a done from either path only ends a transfer that was started here
  a_cmd_done_busy: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    cmd_done_i |-> cmd_busy_q);

  a_dat_done_busy: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    dat_done_i |-> dat_busy_q);

endmodule

/* hw/sd_clk_gen.sv */
// free running SD clock divider with a period of 2 * SDHC_CLK_HALF_DIV cycles of clk_i
// the edge strobes are high in the first clk_i cycle of the new SD clock level
`timescale 1ns/1ps
`include "sdhc_config.svh"

module sd_clk_gen (
  input  logic                 clk_i,
  input  logic                 software_reset_cmd_q,
  output logic                 sd_clk_o,
  output sdhc_pkg::sd_clk_en_t sd_clk_en_o
);

  localparam int unsigned CNT_W = $clog2(`SDHC_CLK_HALF_DIV);

  logic [CNT_W-1:0] cnt_q;
  logic             sd_clk_q, fall_q, rise_q;
  logic             toggle;

  assign toggle = (cnt_q == CNT_W'(`SDHC_CLK_HALF_DIV - 1));

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      cnt_q    <= '0;
      sd_clk_q <= 1'b0;   // bus clock idles low
      fall_q   <= 1'b0;
      rise_q   <= 1'b0;
    end else begin
      fall_q <= toggle && sd_clk_q;
      rise_q <= toggle && !sd_clk_q;
      if (toggle) begin
        cnt_q    <= '0;
        sd_clk_q <= ~sd_clk_q;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign sd_clk_o    = sd_clk_q;
  assign sd_clk_en_o = '{fall: fall_q, rise: rise_q};

  a_half_period: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    sd_clk_en_o.fall |-> ##(`SDHC_CLK_HALF_DIV) sd_clk_en_o.rise);

endmodule

/* hw/sd_cmd_tx.sv */
// CMD line serializer, one bit per SD clock changed on the falling edge
// expects no new start until cmd_done_o, the register block guarantees this
`timescale 1ns/1ps

module sd_cmd_tx (
  input  logic                 clk_i,
  input  logic                 software_reset_cmd_q,
  input  sdhc_pkg::sd_clk_en_t sd_clk_en_i,
  input  sdhc_pkg::cmd_frame_t cmd_frame_i,
  input  logic                 cmd_start_i,
  output logic                 sd_cmd_o,
  output logic                 sd_cmd_en_o,
  output logic                 cmd_done_o
);

  sdhc_pkg::cmd_state_t state_q;
  logic [39:0]          shift_q;    // start, transmission, index, argument
  sdhc_pkg::crc7_t      crc_q, crc_next;
  logic [5:0]           cnt_q;
  logic                 cmd_q, cmd_en_q, done_q;
  logic                 fall, fb;

  assign fall = sd_clk_en_i.fall;

  // serial CRC7, x^7 + x^3 + 1
  assign fb       = shift_q[39] ^ crc_q[6];
  assign crc_next = {crc_q[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);

  always_ff @(posedge clk_i) begin
    if (cmd_start_i && (state_q == sdhc_pkg::cmd_idle))
      shift_q <= {2'b01, cmd_frame_i.index, cmd_frame_i.argument};
    else if (fall && (state_q == sdhc_pkg::cmd_send))
      shift_q <= {shift_q[38:0], 1'b0};
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      state_q  <= sdhc_pkg::cmd_idle;
      cnt_q    <= '0;
      crc_q    <= '0;
      cmd_q    <= 1'b1;
      cmd_en_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        sdhc_pkg::cmd_idle: begin
          if (cmd_start_i) begin
            state_q <= sdhc_pkg::cmd_send;
            cnt_q   <= '0;
            crc_q   <= '0;
          end
        end
        sdhc_pkg::cmd_send: begin
          if (fall) begin
            cmd_q    <= shift_q[39];
            cmd_en_q <= 1'b1;
            crc_q    <= crc_next;
            cnt_q    <= cnt_q + 1'b1;
            if (cnt_q == 6'd39) begin   // last of the 40 covered bits
              state_q <= sdhc_pkg::cmd_crc;
              cnt_q   <= '0;
            end
          end
        end
        sdhc_pkg::cmd_crc: begin
          if (fall) begin
            cmd_q <= crc_q[6];
            crc_q <= {crc_q[5:0], 1'b0};
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == 6'd6) begin
              state_q <= sdhc_pkg::cmd_stop;
              cnt_q   <= '0;
            end
          end
        end
        sdhc_pkg::cmd_stop: begin
          if (fall) begin
            if (cnt_q == 6'd0) begin
              cmd_q <= 1'b1;   // end bit
              cnt_q <= 6'd1;
            end else begin
              cmd_en_q <= 1'b0;
              done_q   <= 1'b1;
              state_q  <= sdhc_pkg::cmd_idle;
            end
          end
        end
        default: state_q <= sdhc_pkg::cmd_idle;
      endcase
    end
  end

  assign sd_cmd_o    = cmd_q;
  assign sd_cmd_en_o = cmd_en_q;
  assign cmd_done_o  = done_q;

endmodule

/* hw/sd_dat_buffer.sv */
// block buffer of SDHC_BLOCK_WORDS words, read out as nibbles MSB first
// a nibble request is answered one cycle later, pushes are gated outside
`timescale 1ns/1ps
`include "sdhc_config.svh"

module sd_dat_buffer (
  input  logic               clk_i,
  input  logic               software_reset_cmd_q,
  input  logic               data_push_i,
  input  sdhc_pkg::word_t    push_word_i,
  input  logic               nibble_req_i,
  input  logic               clear_i,
  output sdhc_pkg::lane_in_t lane_in_o,
  output logic               full_o
);

  localparam int unsigned AW = $clog2(`SDHC_BLOCK_WORDS);
  localparam logic [AW:0] WORDS = `SDHC_BLOCK_WORDS;

  sdhc_pkg::word_t   mem_q [`SDHC_BLOCK_WORDS];
  logic [AW:0]       wr_ptr_q;
  logic [AW-1:0]     rd_ptr_q;
  logic [2:0]        nib_q;    // nibble within the current word
  logic              valid_q;
  sdhc_pkg::nibble_t data_q;

  assign full_o = (wr_ptr_q == WORDS);

  always_ff @(posedge clk_i) begin
    if (data_push_i)
      mem_q[wr_ptr_q[AW-1:0]] <= push_word_i;
  end

  // nibble 0 sits in bits 31:28
  always_ff @(posedge clk_i) begin
    if (nibble_req_i)
      data_q <= mem_q[rd_ptr_q][{~nib_q, 2'b00} +: 4];
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      nib_q    <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= nibble_req_i;
      if (data_push_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (nibble_req_i) begin
        nib_q <= nib_q + 1'b1;
        if (nib_q == 3'd7)
          rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // crc_shift is merged in at the top from the framer
  assign lane_in_o = '{valid: valid_q, data: data_q, crc_shift: 1'b0};

endmodule

/* hw/sd_dat_lane_crc.sv */
// CRC16 of one DAT lane, x^16 + x^12 + x^5 + 1 with initial value 0
// lane_bit_o holds the last data bit, or the CRC bit after a shift request
`timescale 1ns/1ps

module sd_dat_lane_crc (
  input  logic clk_i,
  input  logic software_reset_cmd_q,
  input  logic bit_valid_i,
  input  logic bit_i,
  input  logic crc_shift_i,
  input  logic clear_i,
  output logic lane_bit_o
);

  sdhc_pkg::crc16_t crc_q;
  logic             bit_q;
  logic             fb;

  assign fb = bit_i ^ crc_q[15];

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q || clear_i)
      crc_q <= '0;
    else if (bit_valid_i)
      crc_q <= {crc_q[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    else if (crc_shift_i)
      crc_q <= {crc_q[14:0], 1'b0};   // MSB goes out first
  end

  always_ff @(posedge clk_i) begin
    if (bit_valid_i)
      bit_q <= bit_i;
    else if (crc_shift_i)
      bit_q <= crc_q[15];
  end

  assign lane_bit_o = bit_q;

endmodule

/* hw/sd_dat_framer.sv */
// DAT block sequencer: start bit, block nibbles, 16 CRC bits per lane, end bit
// lane bits must be ready two clk_i cycles after a request, before the next fall
`timescale 1ns/1ps
`include "sdhc_config.svh"

module sd_dat_framer (
  input  logic                 clk_i,
  input  logic                 software_reset_cmd_q,
  input  sdhc_pkg::sd_clk_en_t sd_clk_en_i,
  input  logic                 xfer_start_i,
  input  sdhc_pkg::nibble_t    lane_bits_i,
  output logic                 nibble_req_o,
  output logic                 crc_shift_o,
  output logic                 clear_o,
  output sdhc_pkg::nibble_t    sd_dat_o,
  output logic                 sd_dat_en_o,
  output logic                 dat_done_o
);

  localparam int unsigned NIBBLES = 8 * `SDHC_BLOCK_WORDS;
  localparam int unsigned CW = $clog2(NIBBLES > 16 ? NIBBLES : 16);

  sdhc_pkg::dat_state_t state_q;
  logic [CW-1:0]        cnt_q;
  sdhc_pkg::nibble_t    dat_q;
  logic                 dat_en_q, req_q, shift_q, clear_q, done_q;
  logic                 fall;

  assign fall = sd_clk_en_i.fall;

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      state_q  <= sdhc_pkg::dat_idle;
      cnt_q    <= '0;
      dat_q    <= '1;
      dat_en_q <= 1'b0;
      req_q    <= 1'b0;
      shift_q  <= 1'b0;
      clear_q  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      req_q   <= 1'b0;
      shift_q <= 1'b0;
      clear_q <= 1'b0;
      done_q  <= 1'b0;
      case (state_q)
        sdhc_pkg::dat_idle: begin
          if (xfer_start_i)
            state_q <= sdhc_pkg::dat_start;
        end
        sdhc_pkg::dat_start: begin
          if (fall) begin
            dat_q    <= '0;     // start bit on all lanes
            dat_en_q <= 1'b1;
            req_q    <= 1'b1;   // first nibble goes out on the next fall
            cnt_q    <= '0;
            state_q  <= sdhc_pkg::dat_data;
          end
        end
        sdhc_pkg::dat_data: begin
          if (fall) begin
            dat_q <= lane_bits_i;
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CW'(NIBBLES - 1)) begin
              shift_q <= 1'b1;
              cnt_q   <= '0;
              state_q <= sdhc_pkg::dat_crc;
            end else begin
              req_q <= 1'b1;
            end
          end
        end
        sdhc_pkg::dat_crc: begin
          if (fall) begin
            dat_q <= lane_bits_i;
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CW'(15)) begin
              cnt_q   <= '0;
              state_q <= sdhc_pkg::dat_stop;
            end else begin
              shift_q <= 1'b1;
            end
          end
        end
        sdhc_pkg::dat_stop: begin
          if (fall) begin
            if (cnt_q == '0) begin
              dat_q <= '1;      // end bit
              cnt_q <= CW'(1);
            end else begin
              dat_en_q <= 1'b0;
              done_q   <= 1'b1;
              clear_q  <= 1'b1;  // empties buffer and lane CRCs
              state_q  <= sdhc_pkg::dat_idle;
            end
          end
        end
        default: state_q <= sdhc_pkg::dat_idle;
      endcase
    end
  end

  assign nibble_req_o = req_q;
  assign crc_shift_o  = shift_q;
  assign clear_o      = clear_q;
  assign sd_dat_o     = dat_q;
  assign sd_dat_en_o  = dat_en_q;
  assign dat_done_o   = done_q;

  // buffer answer and lane register both land before the next fall samples them
  a_lane_ready: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    nibble_req_o |-> !fall ##1 !fall);

endmodule

/* hw/sdhc_top.sv */
// SD host transmit path, CMD frames and single DAT blocks, no receive side
// one reset clears everything, outputs are raw pin values plus enables
`timescale 1ns/1ps

module sdhc_top (
  input  logic                   clk_i,
  input  logic                   software_reset_cmd_q,
  input  sdhc_pkg::host_req_t    host_req_i,
  output sdhc_pkg::host_status_t host_status_o,
  output logic                   sd_clk_o,
  output logic                   sd_cmd_o,
  output logic                   sd_cmd_en_o,
  output sdhc_pkg::nibble_t      sd_dat_o,
  output logic                   sd_dat_en_o
);

  sdhc_pkg::sd_clk_en_t sd_clk_en;
  sdhc_pkg::cmd_frame_t cmd_frame;
  sdhc_pkg::word_t      push_word;
  sdhc_pkg::lane_in_t   buf_lane, lane_in;
  sdhc_pkg::nibble_t    lane_bits;
  logic                 cmd_start, cmd_done, dat_done;
  logic                 data_push, xfer_start, buf_full;
  logic                 nibble_req, crc_shift, dat_clear;

  sdhc_regs u_regs (
    .clk_i,
    .software_reset_cmd_q,
    .host_req_i,
    .cmd_done_i    (cmd_done),
    .dat_done_i    (dat_done),
    .buf_full_i    (buf_full),
    .host_status_o,
    .cmd_frame_o   (cmd_frame),
    .cmd_start_o   (cmd_start),
    .data_push_o   (data_push),
    .xfer_start_o  (xfer_start),
    .push_word_o   (push_word)
  );

  sd_clk_gen u_clk_gen (
    .clk_i,
    .software_reset_cmd_q,
    .sd_clk_o,
    .sd_clk_en_o (sd_clk_en)
  );

  sd_cmd_tx u_cmd_tx (
    .clk_i,
    .software_reset_cmd_q,
    .sd_clk_en_i (sd_clk_en),
    .cmd_frame_i (cmd_frame),
    .cmd_start_i (cmd_start),
    .sd_cmd_o,
    .sd_cmd_en_o,
    .cmd_done_o  (cmd_done)
  );

  sd_dat_buffer u_dat_buffer (
    .clk_i,
    .software_reset_cmd_q,
    .data_push_i  (data_push),
    .push_word_i  (push_word),
    .nibble_req_i (nibble_req),
    .clear_i      (dat_clear),
    .lane_in_o    (buf_lane),
    .full_o       (buf_full)
  );

  // buffer nibble plus the framer's CRC shift request
  assign lane_in = '{valid: buf_lane.valid, data: buf_lane.data, crc_shift: crc_shift};

  for (genvar i = 0; i < $bits(sdhc_pkg::nibble_t); i++) begin : g_lane
    sd_dat_lane_crc u_lane_crc (
      .clk_i,
      .software_reset_cmd_q,
      .bit_valid_i (lane_in.valid),
      .bit_i       (lane_in.data[i]),
      .crc_shift_i (lane_in.crc_shift),
      .clear_i     (dat_clear),
      .lane_bit_o  (lane_bits[i])
    );
  end

  sd_dat_framer u_dat_framer (
    .clk_i,
    .software_reset_cmd_q,
    .sd_clk_en_i  (sd_clk_en),
    .xfer_start_i (xfer_start),
    .lane_bits_i  (lane_bits),
    .nibble_req_o (nibble_req),
    .crc_shift_o  (crc_shift),
    .clear_o      (dat_clear),
    .sd_dat_o,
    .sd_dat_en_o,
    .dat_done_o   (dat_done)
  );

endmodule

/* tb/tb_clk_gen.sv */
// clock and reset source of the testbench, 10 ns clock period
// reset stays high for the first 10 rising clock edges
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic software_reset_cmd_q
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    software_reset_cmd_q <= 1'b1;
    repeat (10) @(posedge clk_o);
    software_reset_cmd_q <= 1'b0;
  end

endmodule

/* tb/tb_sdhc.sv */
// testbench of the SD host transmit path with stimulus from a fixed-seed LFSR
// bus bits are taken on rising SD clock edges only and one block is in flight at a time
`timescale 1ns/1ps
`include "sdhc_config.svh"

module tb_sdhc;

  localparam int          WORDS        = `SDHC_BLOCK_WORDS;
  localparam int          HALF         = `SDHC_CLK_HALF_DIV;
  localparam int          CMD_LEN      = 48;
  localparam int          DAT_LEN      = 8 * WORDS + 18;   // SD clocks per data frame
  localparam int          ROUNDS       = 6;
  localparam longint      SD_PERIOD_NS = 2 * HALF * 10;
  localparam longint      WATCHDOG_NS  = (ROUNDS + 2) * (48 + 66) * SD_PERIOD_NS * 4;
  localparam logic [31:0] SEED         = 32'h172efb25;

  typedef logic [32*WORDS-1:0]  block_t;
  typedef logic [4*DAT_LEN-1:0] dat_frame_t;   // wide enough for a command frame too

  logic                   clk, software_reset_cmd_q;
  sdhc_pkg::host_req_t    host_req;
  sdhc_pkg::host_status_t host_status;
  logic                   sd_clk, sd_cmd, sd_cmd_en, sd_dat_en;
  sdhc_pkg::nibble_t      sd_dat;

  logic [CMD_LEN-1:0] exp_cmd[$];
  dat_frame_t         exp_dat[$];
  logic [31:0]        lfsr_q;
  int unsigned        err_stim = 0, err_cap = 0;
  int unsigned        cmd_done_cnt = 0, dat_done_cnt = 0;
  int unsigned        cmd_rd = 0, dat_rd = 0, cmd_len = 0, dat_len = 0;
  logic [CMD_LEN-1:0] cmd_cap;
  dat_frame_t         dat_cap;

  tb_clk_gen u_clk_gen (
    .clk_o                (clk),
    .software_reset_cmd_q (software_reset_cmd_q)
  );

  sdhc_top dut (
    .clk_i                (clk),
    .software_reset_cmd_q (software_reset_cmd_q),
    .host_req_i           (host_req),
    .host_status_o        (host_status),
    .sd_clk_o             (sd_clk),
    .sd_cmd_o             (sd_cmd),
    .sd_cmd_en_o          (sd_cmd_en),
    .sd_dat_o             (sd_dat),
    .sd_dat_en_o          (sd_dat_en)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};   // one step per bit
    end
    return r;
  endfunction

  function automatic block_t random_block();
    block_t blk;
    for (int w = 0; w < WORDS; w++)
      blk[32*(WORDS-w)-1 -: 32] = random_bits(32);   // word 0 on top
    return blk;
  endfunction

  // remainder of the message times x^7 divided by x^7 + x^3 + 1
  function automatic sdhc_pkg::crc7_t crc7_ref(input logic [39:0] bits);
    logic [46:0] r;
    r = {bits, 7'b0};
    for (int i = 46; i >= 7; i--)
      if (r[i])
        r[i -: 8] = r[i -: 8] ^ 8'h89;
    return r[6:0];
  endfunction

  // same long division with x^16 + x^12 + x^5 + 1
  function automatic sdhc_pkg::crc16_t crc16_ref(input logic [8*WORDS-1:0] bits);
    logic [8*WORDS+15:0] r;
    r = {bits, 16'b0};
    for (int i = 8 * WORDS + 15; i >= 16; i--)
      if (r[i])
        r[i -: 17] = r[i -: 17] ^ 17'h11021;
    return r[15:0];
  endfunction

  // bit sequence that one DAT lane carries for a block
  function automatic logic [8*WORDS-1:0] lane_bits(input block_t blk, input int lane);
    logic [8*WORDS-1:0] m;
    for (int k = 0; k < 8 * WORDS; k++)
      m[8*WORDS-1-k] = blk[32*WORDS-4-4*k+lane];
    return m;
  endfunction

  function automatic logic [CMD_LEN-1:0] cmd_frame_ref(input sdhc_pkg::cmd_index_t idx,
                                                       input sdhc_pkg::word_t arg);
    logic [39:0] head;
    head = {1'b0, 1'b1, idx, arg};
    return {head, crc7_ref(head), 1'b1};
  endfunction

  function automatic dat_frame_t dat_frame_ref(input block_t blk);
    dat_frame_t       f;
    sdhc_pkg::crc16_t crc;
    f                          = '0;   // start nibble stays 0
    f[4*DAT_LEN-5 -: 32*WORDS] = blk;
    for (int lane = 0; lane < 4; lane++) begin
      crc = crc16_ref(lane_bits(blk, lane));
      for (int j = 0; j < 16; j++)
        f[4*(16-j)+lane] = crc[15-j];
    end
    f[3:0] = 4'hF;   // end bit on all lanes
    return f;
  endfunction

  task automatic compare(input string name, input dat_frame_t got, input dat_frame_t exp,
                         inout int unsigned errs);
    if (got !== exp) begin
      errs++;
      $display("CHECK FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    end
  endtask

  task automatic host_write(input sdhc_pkg::reg_addr_t reg_addr, input sdhc_pkg::word_t data);
    @(posedge clk);
    host_req <= '{wr: 1'b1, addr: reg_addr, wdata: data};
  endtask

  task automatic host_idle();
    @(posedge clk);
    host_req <= '{wr: 1'b0, addr: '0, wdata: '0};
  endtask

  task automatic send_cmd(input sdhc_pkg::cmd_index_t idx, input sdhc_pkg::word_t arg);
    exp_cmd.push_back(cmd_frame_ref(idx, arg));
    host_write(`SDHC_ADDR_ARG, arg);
    host_write(`SDHC_ADDR_CMD, {26'd0, idx});
  endtask

  task automatic load_block(input block_t blk);
    exp_dat.push_back(dat_frame_ref(blk));
    for (int w = 0; w < WORDS; w++)
      host_write(`SDHC_ADDR_DATA, blk[32*(WORDS-w)-1 -: 32]);
  endtask

  // until every issued command and block has its done pulse
  task automatic wait_idle();
    do
      @(posedge clk);
    while (cmd_done_cnt < exp_cmd.size() || dat_done_cnt < exp_dat.size());
  endtask

  always @(negedge clk) begin
    if (host_status.cmd_done)
      cmd_done_cnt++;
    if (host_status.dat_done)
      dat_done_cnt++;
  end

  // a captured frame is compared on the first rising edge after its enable drops
  always @(posedge sd_clk) begin
    if (sd_cmd_en) begin
      cmd_cap = {cmd_cap[CMD_LEN-2:0], sd_cmd};
      cmd_len++;
    end else if (cmd_len != 0) begin
      if (cmd_rd < exp_cmd.size()) begin
        compare("cmd frame length", dat_frame_t'(cmd_len), dat_frame_t'(CMD_LEN), err_cap);
        compare("sd_cmd_o", dat_frame_t'(cmd_cap), dat_frame_t'(exp_cmd[cmd_rd]), err_cap);
        cmd_rd++;
      end else begin
        err_cap++;
        $display("ERROR t=%0t: command frame on the CMD line with none outstanding", $time);
      end
      cmd_len = 0;
    end
    if (sd_dat_en) begin
      dat_cap = {dat_cap[4*DAT_LEN-5:0], sd_dat};
      dat_len++;
    end else if (dat_len != 0) begin
      if (dat_rd < exp_dat.size()) begin
        compare("dat frame length", dat_frame_t'(dat_len), dat_frame_t'(DAT_LEN), err_cap);
        compare("sd_dat_o", dat_cap, exp_dat[dat_rd], err_cap);
        dat_rd++;
      end else begin
        err_cap++;
        $display("ERROR t=%0t: data frame on the DAT lines with no block outstanding", $time);
      end
      dat_len = 0;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns without the last done pulse", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    block_t               blk;
    sdhc_pkg::cmd_index_t idx;
    sdhc_pkg::word_t      arg;
    logic                 quiet;
    host_req <= '{wr: 1'b0, addr: '0, wdata: '0};
    lfsr_q = SEED;

    repeat (3) @(negedge clk);
    compare("sd_clk_o", dat_frame_t'(sd_clk), '0, err_stim);   // held low in reset
    wait (!software_reset_cmd_q);
    @(negedge clk);
    compare("sd_cmd_en_o", dat_frame_t'(sd_cmd_en), '0, err_stim);
    compare("sd_dat_en_o", dat_frame_t'(sd_dat_en), '0, err_stim);
    compare("sd_cmd_o", dat_frame_t'(sd_cmd), dat_frame_t'(1'b1), err_stim);
    compare("sd_dat_o", dat_frame_t'(sd_dat), dat_frame_t'(4'hF), err_stim);
    compare("host_status_o", dat_frame_t'(host_status), '0, err_stim);

    for (int r = 0; r < ROUNDS; r++) begin
      idx = sdhc_pkg::cmd_index_t'(random_bits(6));
      arg = random_bits(32);
      send_cmd(idx, arg);
      host_idle();
      wait_idle();
      blk = random_block();
      load_block(blk);
      host_write(`SDHC_ADDR_XFER, '0);
      host_idle();
      @(negedge clk);
      compare("dat_busy", dat_frame_t'(host_status.dat_busy), dat_frame_t'(1'b1), err_stim);
      wait_idle();
    end

    // second CMD write lands while busy and after a new argument is stored
    idx = sdhc_pkg::cmd_index_t'(random_bits(6));
    arg = random_bits(32);
    send_cmd(idx, arg);
    host_write(`SDHC_ADDR_ARG, ~arg);
    @(negedge clk);
    compare("cmd_busy", dat_frame_t'(host_status.cmd_busy), dat_frame_t'(1'b1), err_stim);
    host_write(`SDHC_ADDR_CMD, {26'd0, ~idx});
    host_idle();
    wait_idle();
    quiet = 1'b1;
    repeat (CMD_LEN * 2 * HALF) begin
      @(negedge clk);
      if (sd_cmd_en)
        quiet = 1'b0;
    end
    if (!quiet) begin
      err_stim++;
      $display("ERROR t=%0t: a CMD write issued while busy started a second frame", $time);
    end

    // command and block back to back so that both paths run at once
    blk = random_block();
    load_block(blk);
    idx = sdhc_pkg::cmd_index_t'(random_bits(6));
    arg = random_bits(32);
    send_cmd(idx, arg);
    host_write(`SDHC_ADDR_XFER, '0);
    host_idle();
    wait_idle();

    repeat (4 * HALF) @(posedge clk);   // last frames reach their compare edge
    compare("cmd_done pulses", dat_frame_t'(cmd_done_cnt), dat_frame_t'(exp_cmd.size()),
            err_stim);
    compare("dat_done pulses", dat_frame_t'(dat_done_cnt), dat_frame_t'(exp_dat.size()),
            err_stim);
    compare("cmd frames seen", dat_frame_t'(cmd_rd), dat_frame_t'(exp_cmd.size()), err_stim);
    compare("dat frames seen", dat_frame_t'(dat_rd), dat_frame_t'(exp_dat.size()), err_stim);
    $display("cmd frames %0d, data blocks %0d, errors %0d", cmd_rd, dat_rd,
             err_stim + err_cap);
    if (err_stim + err_cap == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* sdhc.f */
+incdir+hw
hw/sdhc_pkg.sv
hw/sdhc_regs.sv
hw/sd_clk_gen.sv
hw/sd_cmd_tx.sv
hw/sd_dat_buffer.sv
hw/sd_dat_lane_crc.sv
hw/sd_dat_framer.sv
hw/sdhc_top.sv
tb/tb_clk_gen.sv
tb/tb_sdhc.sv

/* run_sim.sh */
#!/bin/sh
# builds the SD host testbench with Verilator, runs it and searches the output for the pass line

verilator --binary --timing --assert --top-module tb_sdhc -f sdhc.f \
  || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/Vtb_sdhc)
echo "$out"
echo "$out" | grep -qx "TEST OK" && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }
